/* compile.f */
+incdir+hdl
+incdir+test
hdl/warp_pkg.sv
hdl/warp_imm_gen.sv
hdl/warp_inst_decode.sv
hdl/warp_skid_buffer.sv
hdl/warp_decode.sv
test/tb_warp_decode.sv

/* hdl/warp_cfg.svh */
`ifndef WARP_CFG_SVH
`define WARP_CFG_SVH

// program counter width
`define WARP_XLEN 64

// uncompressed instruction width
`define WARP_ILEN 32

// instructions per fetch group
`define WARP_NUM_SLOTS 2

// architectural register number width
`define WARP_REG_ADDR_W 5

// major opcodes, inst[6:2]
// inst[1:0] is always 2'b11 for 32-bit encodings

// addi, slti, sltiu, xori, ori, andi, slli, srli, srai
`define WARP_OPC_OP_IMM    5'b00100
`define WARP_OPC_AUIPC     5'b00101
// addiw, slliw, srliw, sraiw
`define WARP_OPC_OP_IMM_32 5'b00110
// register-register alu ops
`define WARP_OPC_OP        5'b01100
`define WARP_OPC_LUI       5'b01101
// addw, subw, sllw, srlw, sraw
`define WARP_OPC_OP_32     5'b01110
// beq, bne, blt, bge, bltu, bgeu
`define WARP_OPC_BRANCH    5'b11000

// not executed by this decoder
// but still needed to pick the immediate format
`define WARP_OPC_JALR      5'b11001
`define WARP_OPC_JAL       5'b11011
`define WARP_OPC_LOAD      5'b00000
`define WARP_OPC_STORE     5'b01000

`endif

/* hdl/warp_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module warp_decode (
    input  wire                         i_clk,
    input  wire                         i_rst_n,

    // fetch side, one pair per handshake
    input  wire                         i_fetch_valid,
    output logic                        o_fetch_ready,
    input  wire warp_pkg::fetch_slot_t  i_slot0,
    input  wire warp_pkg::fetch_slot_t  i_slot1,

    // issue side, registered
    output logic                        o_issue_valid,
    input  wire                         i_issue_ready,
    output warp_pkg::decode_pair_t      o_issue_pair
);

    // both decoded bundles, slot0 older
    wire warp_pkg::decode_pair_t dec_pair;

    // combinational decode of the older instruction
    warp_inst_decode slot0 (
        .i_slot   (i_slot0),
        .o_bundle (dec_pair.slot0)
    );

    // padding words from fetch decode like any other instruction
    warp_inst_decode slot1 (
        .i_slot   (i_slot1),
        .o_bundle (dec_pair.slot1)
    );

    // one cycle to issue, holds up to two pairs under stall
    warp_skid_buffer skid0 (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_in_valid  (i_fetch_valid),
        .o_in_ready  (o_fetch_ready),
        .i_in_pair   (dec_pair),
        .o_out_valid (o_issue_valid),
        .i_out_ready (i_issue_ready),
        .o_out_pair  (o_issue_pair)
    );

endmodule

`default_nettype wire

/* hdl/warp_imm_gen.sv */
`timescale 1ns/10ps
`default_nettype none

`include "warp_cfg.svh"

module warp_imm_gen (
    input  wire warp_pkg::inst_t i_inst,
    output warp_pkg::imm_t       o_imm
);

    logic [4:0] opcode;
    logic       fmt_r;
    logic       fmt_s;
    logic       fmt_b;
    logic       fmt_u;
    logic       fmt_j;

    assign opcode = i_inst[6:2];

    // format classes by major opcode
    assign fmt_r = (opcode == `WARP_OPC_OP) || (opcode == `WARP_OPC_OP_32);
    assign fmt_s = opcode == `WARP_OPC_STORE;
    assign fmt_b = opcode == `WARP_OPC_BRANCH;
    assign fmt_u = (opcode == `WARP_OPC_LUI) || (opcode == `WARP_OPC_AUIPC);
    assign fmt_j = opcode == `WARP_OPC_JAL;

    // sign bit is inst[31] in every format
    always_comb begin
        case (1'b1)
            // register forms carry no immediate
            fmt_r: o_imm = '0;
            fmt_s: o_imm = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
            // bit 0 of branch and jump offsets is implied zero
            fmt_b: o_imm = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
            fmt_u: o_imm = {i_inst[31:12], 12'h000};
            fmt_j: o_imm = {{12{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
            // I layout for op-imm, op-imm-32, jalr and load and for unknown opcodes
            default: o_imm = {{20{i_inst[31]}}, i_inst[31:20]};
        endcase
    end

endmodule

`default_nettype wire

/* hdl/warp_inst_decode.sv */
`timescale 1ns/10ps
`default_nettype none

`include "warp_cfg.svh"

module warp_inst_decode (
    input  wire warp_pkg::fetch_slot_t i_slot,
    output warp_pkg::decode_bundle_t   o_bundle
);

    // instruction fields
    logic [4:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_lui;

    // alu opcode group qualifiers
    logic       is_reg;
    logic       is_word;
    logic       f7_zero;
    logic       f7_alt;
    logic       shamt_hi_zero;
    logic       shamt_hi_alt;
    logic       sh_zero;
    logic       sh_alt;
    logic       base_ok;

    // decode results
    logic                    legal;
    warp_pkg::pipe_sel_e     pipe;
    warp_pkg::shared_ctrl_t  shared;
    warp_pkg::xarith_ctrl_t  xarith;
    warp_pkg::xlogic_ctrl_t  xlogic;
    warp_pkg::imm_t          imm;
    warp_pkg::reg_addr_t     rs1;

    assign opcode = i_slot.inst[6:2];
    assign funct3 = i_slot.inst[14:12];
    assign funct7 = i_slot.inst[31:25];
    assign is_lui = opcode == `WARP_OPC_LUI;

    // register-register forms check funct7
    assign is_reg  = (opcode == `WARP_OPC_OP) || (opcode == `WARP_OPC_OP_32);
    // 32-bit forms, result sign extended from bit 31
    assign is_word = (opcode == `WARP_OPC_OP_IMM_32) || (opcode == `WARP_OPC_OP_32);

    assign f7_zero = funct7 == 7'b0000000;
    assign f7_alt  = funct7 == 7'b0100000;

    // rv64 immediate shifts use a 6-bit shamt, so only inst[31:26] is fixed
    assign shamt_hi_zero = i_slot.inst[31:26] == 6'b000000;
    assign shamt_hi_alt  = i_slot.inst[31:26] == 6'b010000;

    // which encoding check applies to shifts
    assign sh_zero = (is_reg || is_word) ? f7_zero : shamt_hi_zero;
    assign sh_alt  = (is_reg || is_word) ? f7_alt : shamt_hi_alt;

    // non-shift register ops need funct7 all zero
    assign base_ok = !is_reg || f7_zero;

    always_comb begin
        legal  = 1'b0;
        pipe   = warp_pkg::PIPE_NONE;
        shared = '0;
        xarith = '0;
        xlogic = '0;

        case (opcode)
            `WARP_OPC_OP_IMM, `WARP_OPC_OP_IMM_32, `WARP_OPC_OP, `WARP_OPC_OP_32: begin
                shared.op2_sel = !is_reg;
                shared.rd_wen  = 1'b1;
                xarith.word    = is_word;
                xlogic.word    = is_word;

                case (funct3)
                    // add, sub, addi and word variants
                    3'b000: begin
                        legal        = is_reg ? (f7_zero || f7_alt) : 1'b1;
                        pipe         = warp_pkg::PIPE_XARITH;
                        xarith.opsel = warp_pkg::XARITH_ADD;
                        xarith.sub   = is_reg && funct7[5];
                    end
                    // left shifts
                    3'b001: begin
                        legal        = sh_zero;
                        pipe         = warp_pkg::PIPE_XLOGIC;
                        xlogic.opsel = warp_pkg::XLOGIC_SHF;
                        xlogic.sll   = 2'b01;
                    end
                    // slt, sltu, no word form
                    3'b010, 3'b011: begin
                        legal              = !is_word && base_ok;
                        pipe               = warp_pkg::PIPE_XARITH;
                        xarith.opsel       = warp_pkg::XARITH_SLT;
                        xarith.sub         = 1'b1;
                        xarith.is_unsigned = funct3[0];
                    end
                    3'b100: begin
                        legal        = !is_word && base_ok;
                        pipe         = warp_pkg::PIPE_XLOGIC;
                        xlogic.opsel = warp_pkg::XLOGIC_XOR;
                    end
                    // srl or sra, inst[30] picks arithmetic
                    3'b101: begin
                        legal        = sh_zero || sh_alt;
                        pipe         = warp_pkg::PIPE_XLOGIC;
                        xlogic.opsel = warp_pkg::XLOGIC_SHF;
                        xlogic.sll   = {i_slot.inst[30], 1'b0};
                    end
                    3'b110: begin
                        legal        = !is_word && base_ok;
                        pipe         = warp_pkg::PIPE_XLOGIC;
                        xlogic.opsel = warp_pkg::XLOGIC_OR;
                    end
                    default: begin
                        legal        = !is_word && base_ok;
                        pipe         = warp_pkg::PIPE_XLOGIC;
                        xlogic.opsel = warp_pkg::XLOGIC_AND;
                    end
                endcase
            end
            // pc plus upper immediate
            `WARP_OPC_AUIPC: begin
                legal          = 1'b1;
                pipe           = warp_pkg::PIPE_XARITH;
                shared.op1_sel = 1'b1;
                shared.op2_sel = 1'b1;
                shared.rd_wen  = 1'b1;
                xarith.opsel   = warp_pkg::XARITH_ADD;
            end
            // x0 plus upper immediate, rs1 forced to zero below
            `WARP_OPC_LUI: begin
                legal          = 1'b1;
                pipe           = warp_pkg::PIPE_XARITH;
                shared.op2_sel = 1'b1;
                shared.rd_wen  = 1'b1;
                xarith.opsel   = warp_pkg::XARITH_ADD;
            end
            // compare rs1 against rs2, target computed elsewhere
            `WARP_OPC_BRANCH: begin
                legal                = (funct3 != 3'b010) && (funct3 != 3'b011);
                pipe                 = warp_pkg::PIPE_XARITH;
                xarith.opsel         = warp_pkg::XARITH_ADD;
                xarith.branch_en     = 1'b1;
                // beq/bne test equality, the rest subtract and look at the sign
                xarith.branch_equal  = !funct3[2];
                xarith.branch_invert = funct3[0];
                xarith.sub           = funct3[2];
                xarith.is_unsigned   = funct3[1];
            end
            default: begin
                legal = 1'b0;
            end
        endcase

        // illegal encodings carry no controls downstream
        if (!legal) begin
            pipe   = warp_pkg::PIPE_NONE;
            shared = '0;
            xarith = '0;
            xlogic = '0;
        end
    end

    // lui reads x0
    assign rs1 = is_lui ? '0 : i_slot.inst[19:15];

    warp_imm_gen imm_gen0 (
        .i_inst (i_slot.inst),
        .o_imm  (imm)
    );

    assign o_bundle = '{
        legal:    legal,
        rs1:      rs1,
        rs2:      i_slot.inst[24:20],
        rd:       i_slot.inst[11:7],
        imm:      imm,
        pipeline: pipe,
        shared:   shared,
        xarith:   xarith,
        xlogic:   xlogic,
        pc_rdata: i_slot.pc_rdata,
        pc_wdata: i_slot.pc_wdata
    };

endmodule

`default_nettype wire

/* hdl/warp_pkg.sv */
`default_nettype none

`include "warp_cfg.svh"

package warp_pkg;

    // raw instruction word
    typedef logic [`WARP_ILEN-1:0] inst_t;
    // pc value
    typedef logic [`WARP_XLEN-1:0] xlen_t;
    // register number
    typedef logic [`WARP_REG_ADDR_W-1:0] reg_addr_t;
    // immediate, already sign extended to 32 bits
    typedef logic [31:0] imm_t;

    // backend pipeline select
    typedef enum logic [3:0] {
        PIPE_NONE   = 4'd0,
        PIPE_XARITH = 4'd1,
        PIPE_XLOGIC = 4'd2
    } pipe_sel_e;

    // xarith unit op
    typedef enum logic [1:0] {
        XARITH_ADD = 2'd0,
        XARITH_SLT = 2'd1
    } xarith_op_e;

    // xlogic unit op
    typedef enum logic [2:0] {
        XLOGIC_AND = 3'd0,
        XLOGIC_OR  = 3'd1,
        XLOGIC_XOR = 3'd2,
        XLOGIC_SHF = 3'd3
    } xlogic_op_e;

    // one instruction as delivered by fetch
    typedef struct packed {
        inst_t inst;
        xlen_t pc_rdata;
        xlen_t pc_wdata;
    } fetch_slot_t;

    // op1_sel picks pc over rs1, op2_sel picks imm over rs2
    typedef struct packed {
        logic op1_sel;
        logic op2_sel;
        logic rd_wen;
    } shared_ctrl_t;

    typedef struct packed {
        xarith_op_e opsel;
        logic       sub;
        logic       is_unsigned;
        logic       cmp_mode;
        logic       branch_en;
        logic       branch_equal;
        logic       branch_invert;
        logic       word;
    } xarith_ctrl_t;

    // sll[0] shift left, sll[1] arithmetic right shift
    typedef struct packed {
        xlogic_op_e opsel;
        logic       invert;
        logic [1:0] sll;
        logic       word;
    } xlogic_ctrl_t;

    // everything issue needs for one instruction
    typedef struct packed {
        logic         legal;
        reg_addr_t    rs1;
        reg_addr_t    rs2;
        reg_addr_t    rd;
        imm_t         imm;
        pipe_sel_e    pipeline;
        shared_ctrl_t shared;
        xarith_ctrl_t xarith;
        xlogic_ctrl_t xlogic;
        xlen_t        pc_rdata;
        xlen_t        pc_wdata;
    } decode_bundle_t;

    // slot0 is the older instruction of the pair
    typedef struct packed {
        decode_bundle_t slot0;
        decode_bundle_t slot1;
    } decode_pair_t;

endpackage

`default_nettype wire

/* hdl/warp_skid_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module warp_skid_buffer (
    input  wire                         i_clk,
    input  wire                         i_rst_n,
    input  wire                         i_in_valid,
    output logic                        o_in_ready,
    input  wire warp_pkg::decode_pair_t i_in_pair,
    output logic                        o_out_valid,
    input  wire                         i_out_ready,
    output warp_pkg::decode_pair_t      o_out_pair
);

    // second entry, only filled while issue stalls
    logic                   skid_valid;
    warp_pkg::decode_pair_t skid_pair;

    logic in_fire;
    logic out_free;
    logic load_out;
    logic load_skid;

    // upstream may send as long as the skid slot is empty
    assign o_in_ready = !skid_valid;
    assign in_fire    = i_in_valid && o_in_ready;

    // output register is empty or drains this cycle
    assign out_free = !o_out_valid || i_out_ready;

    // skid entry has priority to keep order
    assign load_out  = out_free && (skid_valid || in_fire);
    assign load_skid = in_fire && !out_free;

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            o_out_valid <= 1'b0;
            skid_valid  <= 1'b0;
        end else begin
            if (out_free) begin
                o_out_valid <= skid_valid || in_fire;
                skid_valid  <= 1'b0;
            end else if (load_skid) begin
                skid_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (load_out) begin
            o_out_pair <= skid_valid ? skid_pair : i_in_pair;
        end
        if (load_skid) begin
            skid_pair <= i_in_pair;
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the decode testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary -f compile.f --top-module tb_warp_decode -o tb_warp_decode \
    && ./obj_dir/tb_warp_decode \
    || { echo "decode simulation failed"; exit 1; }

/* test/tb_warp_ref.svh */
`ifndef TB_WARP_REF_SVH
`define TB_WARP_REF_SVH

// immediate by instruction format, sign taken from inst[31]
function automatic warp_pkg::imm_t ref_imm(input warp_pkg::inst_t inst);
    logic [19:0] sx;
    sx = {20{inst[31]}};
    case (inst[6:2])
        `WARP_OPC_OP, `WARP_OPC_OP_32: ref_imm = '0;
        `WARP_OPC_STORE: ref_imm = {sx, inst[31:25], inst[11:7]};
        `WARP_OPC_BRANCH: ref_imm = {sx[18:0], inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        `WARP_OPC_LUI, `WARP_OPC_AUIPC: ref_imm = {inst[31:12], 12'h000};
        `WARP_OPC_JAL: ref_imm = {sx[10:0], inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        // I layout, also for anything unlisted
        default: ref_imm = {sx, inst[31:20]};
    endcase
endfunction

// expected bundle from the decode table
function automatic warp_pkg::decode_bundle_t ref_decode(input warp_pkg::fetch_slot_t s);
    warp_pkg::decode_bundle_t b;
    logic [4:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       rr;
    logic       w;
    opc = s.inst[6:2];
    f3  = s.inst[14:12];
    f7  = s.inst[31:25];
    rr  = (opc == `WARP_OPC_OP) || (opc == `WARP_OPC_OP_32);
    w   = (opc == `WARP_OPC_OP_IMM_32) || (opc == `WARP_OPC_OP_32);
    b = '0;
    b.rs1      = (opc == `WARP_OPC_LUI) ? 5'd0 : s.inst[19:15];
    b.rs2      = s.inst[24:20];
    b.rd       = s.inst[11:7];
    b.imm      = ref_imm(s.inst);
    b.pc_rdata = s.pc_rdata;
    b.pc_wdata = s.pc_wdata;
    case (opc)
        `WARP_OPC_OP_IMM, `WARP_OPC_OP_IMM_32, `WARP_OPC_OP, `WARP_OPC_OP_32: begin
            b.shared.op2_sel = !rr;
            b.shared.rd_wen  = 1'b1;
            b.xarith.word    = w;
            b.xlogic.word    = w;
            if (f3 == 3'b000) begin
                b.legal      = !rr || f7 == 7'h00 || f7 == 7'h20;
                b.pipeline   = warp_pkg::PIPE_XARITH;
                b.xarith.sub = rr && f7 == 7'h20;
            end else if (f3[1:0] == 2'b01) begin
                // 64-bit immediate shifts only fix funct6
                b.legal = (rr || w) ? (f7 == 7'h00 || (f3[2] && f7 == 7'h20))
                                    : (f7[6:1] == 6'h00 || (f3[2] && f7[6:1] == 6'h10));
                b.pipeline     = warp_pkg::PIPE_XLOGIC;
                b.xlogic.opsel = warp_pkg::XLOGIC_SHF;
                b.xlogic.sll   = f3[2] ? {s.inst[30], 1'b0} : 2'b01;
            end else begin
                // compares and bitwise ops have no word form
                b.legal = !w && (!rr || f7 == 7'h00);
                b.pipeline = f3[2] ? warp_pkg::PIPE_XLOGIC : warp_pkg::PIPE_XARITH;
                b.xarith.opsel = f3[2] ? warp_pkg::XARITH_ADD : warp_pkg::XARITH_SLT;
                b.xarith.sub = !f3[2];
                b.xarith.is_unsigned = !f3[2] && f3[0];
                b.xlogic.opsel = (f3 == 3'b100) ? warp_pkg::XLOGIC_XOR :
                                 (f3 == 3'b110) ? warp_pkg::XLOGIC_OR : warp_pkg::XLOGIC_AND;
            end
        end
        `WARP_OPC_LUI, `WARP_OPC_AUIPC: begin
            b.legal          = 1'b1;
            b.pipeline       = warp_pkg::PIPE_XARITH;
            // auipc adds pc, lui adds x0
            b.shared.op1_sel = opc == `WARP_OPC_AUIPC;
            b.shared.op2_sel = 1'b1;
            b.shared.rd_wen  = 1'b1;
        end
        `WARP_OPC_BRANCH: begin
            b.legal                = f3[2:1] != 2'b01;
            b.pipeline             = warp_pkg::PIPE_XARITH;
            b.xarith.branch_en     = 1'b1;
            b.xarith.branch_equal  = !f3[2];
            b.xarith.branch_invert = f3[0];
            b.xarith.sub           = f3[2];
            b.xarith.is_unsigned   = f3[1];
        end
        default: b.legal = 1'b0;
    endcase
    // no controls leave with an illegal word
    if (!b.legal) begin
        b.pipeline = warp_pkg::PIPE_NONE;
        b.shared   = '0;
        b.xarith   = '0;
        b.xlogic   = '0;
    end
    ref_decode = b;
endfunction

`endif

/* test/tb_warp_decode.sv */
`timescale 1ns/10ps
`default_nettype none

`include "warp_cfg.svh"

module tb_warp_decode;

    `include "tb_warp_ref.svh"

    // first part at full rate, rest with random valid and ready
    localparam int NUM_FULL    = 300;
    localparam int TOTAL_PAIRS = 600;

    // opcodes whose immediate layouts get random bits
    localparam logic [4:0] FMT_OPC [0:10] = '{`WARP_OPC_OP_IMM, `WARP_OPC_AUIPC,
        `WARP_OPC_OP_IMM_32, `WARP_OPC_OP, `WARP_OPC_LUI, `WARP_OPC_OP_32, `WARP_OPC_BRANCH,
        `WARP_OPC_JALR, `WARP_OPC_JAL, `WARP_OPC_LOAD, `WARP_OPC_STORE};

    logic                   i_clk;
    logic                   i_rst_n;
    logic                   i_fetch_valid;
    logic                   o_fetch_ready;
    warp_pkg::fetch_slot_t  i_slot0;
    warp_pkg::fetch_slot_t  i_slot1;
    logic                   o_issue_valid;
    logic                   i_issue_ready;
    warp_pkg::decode_pair_t o_issue_pair;

    integer                 seed = 32'h2842_4f4f;
    warp_pkg::fetch_slot_t  stim [TOTAL_PAIRS][2];
    // expected pairs in fetch order
    warp_pkg::decode_pair_t exp_q [$];
    warp_pkg::decode_pair_t held_pair;
    logic                   stalled;
    int                     checked;

    warp_decode dut0 (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_fetch_valid (i_fetch_valid),
        .o_fetch_ready (o_fetch_ready),
        .i_slot0       (i_slot0),
        .i_slot1       (i_slot1),
        .o_issue_valid (o_issue_valid),
        .i_issue_ready (i_issue_ready),
        .o_issue_pair  (o_issue_pair)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "decode testbench stopped on an error");
    endtask

    task automatic compare_bundle(input string name, input warp_pkg::decode_bundle_t exp,
                                  input warp_pkg::decode_bundle_t act);
        if (act !== exp)
            fail_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    endtask

    task automatic compare_ctrl(input string name, input logic exp, input logic act);
        if (act !== exp)
            fail_run($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
    endtask

    // kind 0 legal, 1 any bits under a listed opcode, else illegal
    function automatic warp_pkg::inst_t gen_inst(input logic [1:0] kind, input logic [31:0] r,
                                                 input logic [31:0] s);
        warp_pkg::inst_t inst;
        logic [2:0]      wf3;
        logic [6:0]      alt7;
        inst = {r[31:2], 2'b11};
        // word forms only have add and shifts
        wf3  = (r[13:12] == 2'd0) ? 3'b000 : ((r[13:12] == 2'd1) ? 3'b001 : 3'b101);
        alt7 = {1'b0, r[30], 5'b00000};
        if (kind == 2'd0) begin
            case (s[2:0])
                3'd0: begin
                    inst[6:2] = `WARP_OPC_OP_IMM;
                    // shifts keep the 6-bit shamt
                    if (inst[13:12] == 2'b01)
                        inst[31:26] = {1'b0, r[30] & inst[14], 4'b0000};
                end
                3'd1: begin
                    inst[6:2]   = `WARP_OPC_OP_IMM_32;
                    inst[14:12] = wf3;
                    if (wf3 != 3'b000)
                        inst[31:25] = (wf3 == 3'b001) ? 7'd0 : alt7;
                end
                3'd2: begin
                    inst[6:2]   = `WARP_OPC_OP;
                    inst[31:25] = (inst[14:12] == 3'b000 || inst[14:12] == 3'b101) ? alt7 : 7'd0;
                end
                3'd3: begin
                    inst[6:2]   = `WARP_OPC_OP_32;
                    inst[14:12] = wf3;
                    inst[31:25] = (wf3 == 3'b001) ? 7'd0 : alt7;
                end
                3'd4: inst[6:2] = `WARP_OPC_LUI;
                3'd5: inst[6:2] = `WARP_OPC_AUIPC;
                default: begin
                    inst[6:2] = `WARP_OPC_BRANCH;
                    // 010 and 011 turn into beq and bne
                    if (inst[14:13] == 2'b01)
                        inst[13] = 1'b0;
                end
            endcase
        end else if (kind == 2'd1) begin
            if (s[3:0] < 4'd11)
                inst[6:2] = FMT_OPC[s[3:0]];
        end else begin
            case (s[2:0])
                // slli with a nonzero funct6
                3'd0: inst = {1'b1, r[30:15], 3'b001, r[11:7], `WARP_OPC_OP_IMM, 2'b11};
                // mul encoding, funct7 0000001
                3'd1: inst = {7'b0000001, r[24:15], 3'b000, r[11:7], `WARP_OPC_OP, 2'b11};
                3'd2: inst = {r[31:15], 2'b01, r[12:7], `WARP_OPC_BRANCH, 2'b11};
                3'd3: inst[6:2] = 5'b11100;
                3'd4: inst[6:2] = `WARP_OPC_LOAD;
                3'd5: inst[6:2] = `WARP_OPC_JAL;
                default: begin
                    // random opcode, listed ones swapped for misc-mem
                    if (r[6:2] inside {`WARP_OPC_OP_IMM, `WARP_OPC_AUIPC, `WARP_OPC_OP_IMM_32,
                                       `WARP_OPC_OP, `WARP_OPC_LUI, `WARP_OPC_OP_32,
                                       `WARP_OPC_BRANCH})
                        inst[6:2] = 5'b00011;
                end
            endcase
        end
        gen_inst = inst;
    endfunction

    initial begin
        logic [31:0]     r;
        logic [31:0]     s;
        logic [1:0]      kind;
        warp_pkg::xlen_t pc;
        int              idx;
        i_rst_n       <= 1'b1;
        i_fetch_valid <= 1'b0;
        i_slot0       <= '0;
        i_slot1       <= '0;
        i_issue_ready <= 1'b1;
        // slot1 pc follows slot0 so a swap shows up
        for (int k = 0; k < TOTAL_PAIRS; k++) begin
            r  = $random(seed);
            pc = {~r, r[31:2], 2'b00};
            for (int j = 0; j < 2; j++) begin
                r = $random(seed);
                s = $random(seed);
                kind = (k < NUM_FULL) ? 2'((k + j) % 3) : s[5:4];
                stim[k][j] = '{inst: gen_inst(kind, r, s), pc_rdata: pc, pc_wdata: pc + 64'd4};
                pc = pc + 64'd4;
            end
        end
        repeat (8) @(posedge i_clk);
        i_rst_n <= 1'b0;
        @(posedge i_clk);
        compare_ctrl("reset fetch_ready", 1'b1, o_fetch_ready);
        compare_ctrl("reset issue_valid", 1'b0, o_issue_valid);
        idx = 0;
        while (idx < TOTAL_PAIRS) begin
            @(posedge i_clk);
            // full rate, one pair in and one out each cycle
            if (idx > 0 && idx < NUM_FULL) begin
                compare_ctrl("full rate fetch_ready", 1'b1, o_fetch_ready);
                compare_ctrl("full rate issue_valid", 1'b1, o_issue_valid);
            end
            if (i_fetch_valid && o_fetch_ready) begin
                exp_q.push_back({ref_decode(i_slot0), ref_decode(i_slot1)});
                idx++;
            end
            r = $random(seed);
            i_issue_ready <= (idx < NUM_FULL) ? 1'b1 : (r[3:0] < 4'd10);
            // an offered pair stays until taken
            if (!i_fetch_valid || o_fetch_ready) begin
                if (idx < TOTAL_PAIRS && (idx < NUM_FULL || r[7:4] < 4'd11)) begin
                    i_slot0       <= stim[idx][0];
                    i_slot1       <= stim[idx][1];
                    i_fetch_valid <= 1'b1;
                end else begin
                    i_fetch_valid <= 1'b0;
                end
            end
        end
        // at most two pairs left in the buffer
        i_issue_ready <= 1'b1;
        repeat (4) @(posedge i_clk);
        if (exp_q.size() != 0) begin
            fail_run($sformatf("%0d pairs were lost between fetch and issue", exp_q.size()));
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

    // issue side scoreboard
    always @(posedge i_clk) begin : check_issue
        warp_pkg::decode_pair_t exp_pair;
        if (i_rst_n) begin
            stalled = 1'b0;
            checked = 0;
        end else begin
            // stalled pair must be offered again unchanged
            if (stalled) begin
                compare_ctrl("stall valid hold", 1'b1, o_issue_valid);
                compare_bundle("stall slot0 hold", held_pair.slot0, o_issue_pair.slot0);
                compare_bundle("stall slot1 hold", held_pair.slot1, o_issue_pair.slot1);
            end
            if (o_issue_valid && i_issue_ready) begin
                if (exp_q.size() == 0) begin
                    fail_run("issue handshake with no pair outstanding");
                end else begin
                    exp_pair = exp_q.pop_front();
                    compare_bundle($sformatf("pair %0d slot0", checked), exp_pair.slot0,
                                   o_issue_pair.slot0);
                    compare_bundle($sformatf("pair %0d slot1", checked), exp_pair.slot1,
                                   o_issue_pair.slot1);
                    checked++;
                end
            end
            stalled   = o_issue_valid && !i_issue_ready;
            held_pair = o_issue_pair;
        end
    end

    // bound on run length, four cycles per pair plus margin
    initial begin
        repeat (TOTAL_PAIRS * 4 + 100) @(posedge i_clk);
        fail_run("watchdog timeout before all pairs were checked");
    end

endmodule

`default_nettype wire
